/* hdl/isaPkg.sv */
package isaPkg;

  // one data word, register value or memory address
  typedef logic [15:0] wordT;

  // register number, x y and z fields
  typedef logic [3:0] regIndexT;

  // register 15 doubles as the program counter
  localparam regIndexT PcIndex = 4'd15;

  typedef enum logic [3:0]
  {
    OpAdd      = 4'b0000,  // Rx = Ry + Rz
    OpOr       = 4'b0001,  // Rx = Ry | Rz
    OpAnd      = 4'b0010,  // Rx = Ry & Rz
    OpNot      = 4'b0011,  // Rx = ~Ry
    OpCondCopy = 4'b1011,  // Rx = Ry if Rz != 0
    OpStore    = 4'b1100,  // mem[Ry] = Rx
    OpLoad     = 4'b1101,  // Rx = mem[Ry]
    OpCopy     = 4'b1110   // Rx = Ry
  } opcodeT;

  // same field layout for every instruction
  typedef struct packed
  {
    opcodeT   opcode;  // bits 15:12
    regIndexT x;       // destination, or store source
    regIndexT y;       // first operand, or memory address
    regIndexT z;       // second operand, or copy condition
  } instructionT;

  // register bank write port
  typedef struct packed
  {
    logic     enable;
    regIndexT index;
    wordT     data;
  } regWriteT;

endpackage

/* hdl/wbPkg.sv */
package wbPkg;

  // Wishbone classic, master to slave
  typedef struct packed
  {
    logic        cyc;
    logic        stb;
    logic        we;   // high for a write cycle
    logic [15:0] adr;
    logic [15:0] dat;  // write data
  } wbReqT;

  // Wishbone classic, slave to master
  typedef struct packed
  {
    logic        ack;  // one cycle per request
    logic [15:0] dat;  // read data, valid with ack
  } wbRspT;

endpackage

/* hdl/registerBank.sv */
`timescale 1ns/100ps

module registerBank
#(
  parameter isaPkg::wordT ResetPc = 16'h0000
)
(
  input  logic             Clock,
  input  logic             arstN,
  input  isaPkg::regIndexT readSelA,
  input  isaPkg::regIndexT readSelB,
  output isaPkg::wordT     readA,
  output isaPkg::wordT     readB,
  input  isaPkg::regWriteT write,
  input  logic             pcIncrement,
  output isaPkg::wordT     pc
);

  isaPkg::wordT generalRegs [0:14];  // registers 0 to 14
  isaPkg::wordT pcReg;
  logic         writeGeneral;
  logic         writePc;

  assign writePc      = write.enable && (write.index == isaPkg::PcIndex);
  assign writeGeneral = write.enable && (write.index != isaPkg::PcIndex);

  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < 15; i++)
      begin
        generalRegs[i] <= '0;
      end
    end
    else if (writeGeneral)
    begin
      generalRegs[write.index] <= write.data;
    end
  end

  // a write to register 15 is a jump and wins over the increment
  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
    begin
      pcReg <= ResetPc;
    end
    else if (writePc)
    begin
      pcReg <= write.data;
    end
    else if (pcIncrement)
    begin
      pcReg <= pcReg + 16'd1;
    end
  end

  assign readA = (readSelA == isaPkg::PcIndex) ? pcReg : generalRegs[readSelA];
  assign readB = (readSelB == isaPkg::PcIndex) ? pcReg : generalRegs[readSelB];
  assign pc    = pcReg;  // fetch address

endmodule

/* hdl/busInterface.sv */
`timescale 1ns/100ps

module busInterface
(
  input  logic          Clock,
  input  logic          arstN,
  input  logic          busStart,
  input  logic          busWrite,
  input  isaPkg::wordT  busAddress,
  input  isaPkg::wordT  busWriteData,
  output logic          busDone,
  output isaPkg::wordT  busReadData,
  output wbPkg::wbReqT  wbOut,
  input  wbPkg::wbRspT  wbIn
);

  logic         active;     // cyc and stb
  logic         writeReg;
  isaPkg::wordT addressReg;
  isaPkg::wordT dataReg;

  // one cycle per request, ended by ack
  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
    begin
      active   <= 1'b0;
      writeReg <= 1'b0;
    end
    else if (busStart)
    begin
      active   <= 1'b1;
      writeReg <= busWrite;
    end
    else if (active && wbIn.ack)
    begin
      active   <= 1'b0;
      writeReg <= 1'b0;  // we low between cycles
    end
  end

  // held stable until ack
  always_ff @(posedge Clock)
  begin
    if (busStart)
    begin
      addressReg <= busAddress;
      dataReg    <= busWriteData;
    end
  end

  assign wbOut = '{cyc: active,
                   stb: active,
                   we:  writeReg,
                   adr: addressReg,
                   dat: dataReg};

  // done on the edge that samples ack
  assign busDone     = active && wbIn.ack;
  assign busReadData = wbIn.dat;

endmodule

/* hdl/stepControl.sv */
`timescale 1ns/100ps

module stepControl
(
  input  logic             Clock,
  input  logic             arstN,
  input  isaPkg::wordT     pc,
  output isaPkg::regIndexT readSelA,
  output isaPkg::regIndexT readSelB,
  input  isaPkg::wordT     readA,
  input  isaPkg::wordT     readB,
  output isaPkg::regWriteT regWrite,
  output logic             pcIncrement,
  output logic             busStart,
  output logic             busWrite,
  output isaPkg::wordT     busAddress,
  output isaPkg::wordT     busWriteData,
  input  logic             busDone,
  input  isaPkg::wordT     busReadData
);

  typedef enum logic [1:0]
  {
    Fetch     = 2'b00,
    Execute   = 2'b01,
    Memory    = 2'b10,
    Writeback = 2'b11
  } stepT;

  stepT                step;
  logic                pending;    // bus request outstanding
  logic                condPass;   // Rz nonzero, sampled in Execute
  isaPkg::instructionT instr;
  isaPkg::wordT        result;     // ALU result or memory address
  isaPkg::wordT        loadData;
  isaPkg::wordT        aluOut;
  logic                isStore;
  logic                isLoad;
  logic                writesReg;

  assign isStore = (instr.opcode == isaPkg::OpStore);
  assign isLoad  = (instr.opcode == isaPkg::OpLoad);

  // store reads x and y, everything else y and z
  assign readSelA = isStore ? instr.x : instr.y;
  assign readSelB = isStore ? instr.y : instr.z;

  always_comb
  begin
    case (instr.opcode)
      isaPkg::OpAdd:      aluOut = readA + readB;
      isaPkg::OpOr:       aluOut = readA | readB;
      isaPkg::OpAnd:      aluOut = readA & readB;
      isaPkg::OpNot:      aluOut = ~readA;
      isaPkg::OpCopy:     aluOut = readA;
      isaPkg::OpCondCopy: aluOut = readA;
      isaPkg::OpLoad:     aluOut = readA;  // address is Ry
      isaPkg::OpStore:    aluOut = readB;  // address is Ry on port B
      default:            aluOut = '0;
    endcase
  end

  // which instructions end with a register write
  always_comb
  begin
    case (instr.opcode)
      isaPkg::OpAdd,
      isaPkg::OpOr,
      isaPkg::OpAnd,
      isaPkg::OpNot,
      isaPkg::OpCopy,
      isaPkg::OpLoad:     writesReg = 1'b1;
      isaPkg::OpCondCopy: writesReg = condPass;
      default:            writesReg = 1'b0;  // store and unused opcodes
    endcase
  end

  always_ff @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
    begin
      step     <= Fetch;
      pending  <= 1'b0;
      condPass <= 1'b0;
    end
    else
    begin
      if (busStart)
      begin
        pending <= 1'b1;
      end
      else if (busDone)
      begin
        pending <= 1'b0;
      end

      case (step)
        Fetch:
        begin
          if (busDone)
          begin
            step <= Execute;
          end
        end
        Execute:
        begin
          condPass <= (readB != '0);  // Rz for conditional copy
          step     <= (isLoad || isStore) ? Memory : Writeback;
        end
        Memory:
        begin
          if (busDone)
          begin
            step <= Writeback;
          end
        end
        Writeback:
        begin
          step <= Fetch;
        end
        default:
        begin
          step <= Fetch;
        end
      endcase
    end
  end

  always_ff @(posedge Clock)
  begin
    if ((step == Fetch) && busDone)
    begin
      instr <= isaPkg::instructionT'(busReadData);
    end
    if (step == Execute)
    begin
      result <= aluOut;
    end
    if ((step == Memory) && busDone)
    begin
      loadData <= busReadData;
    end
  end

  // one request per bus step, never while one is open
  assign busStart     = ((step == Fetch) || (step == Memory)) && !pending;
  assign busWrite     = (step == Memory) && isStore;
  assign busAddress   = (step == Memory) ? result : pc;
  assign busWriteData = readA;  // Rx for store

  assign pcIncrement = (step == Fetch) && busDone;

  // destination is always x
  assign regWrite = '{enable: (step == Writeback) && writesReg,
                      index:  instr.x,
                      data:   isLoad ? loadData : result};

endmodule

/* hdl/processorTop.sv */
`timescale 1ns/100ps

module processorTop
#(
  parameter isaPkg::wordT ResetPc = 16'h0000
)
(
  input  logic         Clock,
  input  logic         arstN,
  output wbPkg::wbReqT wbOut,
  input  wbPkg::wbRspT wbIn
);

  isaPkg::regIndexT readSelA;
  isaPkg::regIndexT readSelB;
  isaPkg::wordT     readA;
  isaPkg::wordT     readB;
  isaPkg::regWriteT regWrite;
  logic             pcIncrement;
  isaPkg::wordT     pc;
  logic             busStart;
  logic             busWrite;
  isaPkg::wordT     busAddress;
  isaPkg::wordT     busWriteData;
  logic             busDone;
  isaPkg::wordT     busReadData;

  registerBank #(.ResetPc(ResetPc)) bank
  (
    .Clock       (Clock),
    .arstN       (arstN),
    .readSelA    (readSelA),
    .readSelB    (readSelB),
    .readA       (readA),
    .readB       (readB),
    .write       (regWrite),
    .pcIncrement (pcIncrement),
    .pc          (pc)
  );

  stepControl control
  (
    .Clock        (Clock),
    .arstN        (arstN),
    .pc           (pc),
    .readSelA     (readSelA),
    .readSelB     (readSelB),
    .readA        (readA),
    .readB        (readB),
    .regWrite     (regWrite),
    .pcIncrement  (pcIncrement),
    .busStart     (busStart),
    .busWrite     (busWrite),
    .busAddress   (busAddress),
    .busWriteData (busWriteData),
    .busDone      (busDone),
    .busReadData  (busReadData)
  );

  busInterface bus
  (
    .Clock        (Clock),
    .arstN        (arstN),
    .busStart     (busStart),
    .busWrite     (busWrite),
    .busAddress   (busAddress),
    .busWriteData (busWriteData),
    .busDone      (busDone),
    .busReadData  (busReadData),
    .wbOut        (wbOut),
    .wbIn         (wbIn)
  );

endmodule

/* test/stepControl_props.sv */
`timescale 1ns/100ps

module stepControlProps
(
  input logic         Clock,
  input logic         arstN,
  input wbPkg::wbReqT wbOut,
  input wbPkg::wbRspT wbIn,
  input logic [1:0]   step,    // Fetch 0, Execute 1, Memory 2, Writeback 3
  input logic [3:0]   opcode
);

  logic memOp;
  int   violationCount;  // assertion failures so far

  assign memOp = (opcode == isaPkg::OpLoad) || (opcode == isaPkg::OpStore);

  stbInsideCyc: assert property (@(posedge Clock) disable iff (!arstN)
    wbOut.stb |-> wbOut.cyc)
  else
  begin
    $error("stb is high while cyc is low");
    violationCount++;
  end

  requestHeld: assert property (@(posedge Clock) disable iff (!arstN)
    wbOut.stb && !wbIn.ack |=> $stable(wbOut.adr) && $stable(wbOut.we) && $stable(wbOut.dat))
  else
  begin
    $error("bus request changed before ack");
    violationCount++;
  end

  fetchOrder: assert property (@(posedge Clock) disable iff (!arstN)
    step == 2'd0 |=> step inside {2'd0, 2'd1})
  else
  begin
    $error("Fetch was not followed by Execute");
    violationCount++;
  end

  // only load and store pass through Memory
  executeOrder: assert property (@(posedge Clock) disable iff (!arstN)
    step == 2'd1 |=> step == (memOp ? 2'd2 : 2'd3))
  else
  begin
    $error("Execute went to the wrong step");
    violationCount++;
  end

  memoryOrder: assert property (@(posedge Clock) disable iff (!arstN)
    step == 2'd2 |=> step inside {2'd2, 2'd3})
  else
  begin
    $error("Memory was not followed by Writeback");
    violationCount++;
  end

  writebackOrder: assert property (@(posedge Clock) disable iff (!arstN)
    step == 2'd3 |=> step == 2'd0)
  else
  begin
    $error("Writeback was not followed by Fetch");
    violationCount++;
  end

endmodule

/* test/processorTb.sv */
`timescale 1ns/100ps

module processorTb;

  localparam isaPkg::wordT ResetPc = 16'h0010;
  localparam int FetchTarget    = 50;    // 46 instructions, then the loop at 0x4c
  localparam int ExpectedStores = 10;
  localparam int CycleLimit     = 2000;  // 50 instructions of up to 14 cycles, with margin

  // loads, ALU ops, copies and stores from ResetPc, jump to 0x40 at 0x30
  localparam isaPkg::wordT MainCode [0:34] = '{
    16'hD100, 16'hD210, 16'hD320, 16'h0421, 16'hD540, 16'h0441, 16'hD640, 16'h0441,  // 0x10
    16'hD740, 16'h0835, 16'hC870, 16'h0771, 16'h1836, 16'hC870, 16'h0771, 16'h2865,  // 0x18
    16'hC870, 16'h0771, 16'h3830, 16'hC870, 16'h0771, 16'hE960, 16'hBA30, 16'hBB51,  // 0x20
    16'hC970, 16'h0771, 16'hCA70, 16'h0771, 16'hCB70, 16'h0771, 16'h0441, 16'hDD40,  // 0x28
    16'hEFD0, 16'h3800, 16'hC870};  // last two words must be skipped
  // PC copy, reload, nop, untaken and taken conditional jumps
  localparam isaPkg::wordT JumpCode [0:12] = '{
    16'hEEF0, 16'hCE70, 16'h0771, 16'hDC20, 16'h0CCC, 16'hCC70, 16'h0771, 16'h4123,
    16'hBFD0, 16'h0441, 16'hDD40, 16'hCD70, 16'hBFD1};
  localparam isaPkg::wordT DataWords [0:5] = '{
    16'h1234, 16'h0F0F, 16'hA5C3, 16'h00A0, 16'h0040, 16'h004C};  // at 0x80

  typedef struct packed
  {
    logic         memAccess;
    logic         memWrite;
    isaPkg::wordT memAddress;
    isaPkg::wordT storeData;
    isaPkg::wordT nextPc;
  } refStepT;

  logic         Clock;
  logic         arstN;
  wbPkg::wbReqT wbOut;
  wbPkg::wbRspT wbIn = '0;
  isaPkg::wordT memory [0:255];
  isaPkg::wordT refMem [0:255];
  isaPkg::wordT refRegs [0:15];   // entry 15 is the model PC
  isaPkg::wordT expectedPc;
  refStepT      pendingStep;
  logic         memPending;       // a load or store cycle comes next
  logic [15:0]  lfsrState;
  logic         counting;
  logic [1:0]   waitLeft;
  logic [1:0]   waitNow;
  int           mismatchCount;
  int           failureCount;
  int           fetchCount;
  int           storeCount;
  int           cycleCount;

  processorTop #(.ResetPc(ResetPc)) dut
  (
    .Clock (Clock),
    .arstN (arstN),
    .wbOut (wbOut),
    .wbIn  (wbIn)
  );

  bind processorTop stepControlProps props
  (
    .Clock  (Clock),
    .arstN  (arstN),
    .wbOut  (wbOut),
    .wbIn   (wbIn),
    .step   (control.step),
    .opcode (control.instr.opcode)
  );

  initial
  begin
    Clock = 1'b0;
    forever
      #50 Clock = ~Clock;  // 100 ns period
  end

  initial
  begin
    arstN      <= 1'b0;
    memPending = 1'b0;
    lfsrState  = 16'd16619;
    expectedPc = ResetPc;
    for (int a = 0; a < 256; a++)
    begin
      memory[a] = {8'h40, 8'(a)};  // unused opcode, runs as a nop
    end
    memory[0] = 16'h0001;
    memory[1] = 16'h0080;  // pointer to the data words
    foreach (MainCode[i])
      memory[16 + i] = MainCode[i];
    foreach (JumpCode[i])
      memory[64 + i] = JumpCode[i];
    foreach (DataWords[i])
      memory[128 + i] = DataWords[i];
    refMem = memory;
    foreach (refRegs[r])
      refRegs[r] = '0;
    refRegs[15] = ResetPc;
    repeat (10) @(posedge Clock);
    arstN <= 1'b1;
  end

  // taps 16 14 13 11
  function automatic logic lfsrBit();
    logic feedback;
    feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], feedback};
    return feedback;
  endfunction

  function automatic logic [1:0] drawWait();
    logic [1:0] cycles;
    cycles[1] = lfsrBit();
    cycles[0] = lfsrBit();
    return cycles;
  endfunction

  // slave with 0 to 3 wait cycles per request
  always @(posedge Clock or negedge arstN)
  begin
    if (!arstN)
    begin
      wbIn     <= '0;
      counting <= 1'b0;
      waitLeft <= 2'd0;
    end
    else if (wbIn.ack)
    begin
      wbIn.ack <= 1'b0;  // one ack per request
    end
    else if (wbOut.cyc && wbOut.stb)
    begin
      waitNow = counting ? waitLeft : drawWait();
      if (waitNow == 2'd0)
      begin
        counting <= 1'b0;
        wbIn.ack <= 1'b1;
        wbIn.dat <= memory[wbOut.adr[7:0]];
        if (wbOut.we)
          memory[wbOut.adr[7:0]] = wbOut.dat;
      end
      else
      begin
        counting <= 1'b1;
        waitLeft <= waitNow - 2'd1;
      end
    end
  end

  // executes one instruction at the model PC
  function automatic refStepT modelInstruction();
    isaPkg::instructionT instr;
    isaPkg::wordT        ry;
    isaPkg::wordT        rz;
    refStepT             outcome;
    instr       = isaPkg::instructionT'(refMem[refRegs[15][7:0]]);
    refRegs[15] = refRegs[15] + 16'd1;  // operands see the incremented PC
    ry          = refRegs[instr.y];
    rz          = refRegs[instr.z];
    outcome     = '0;
    case (instr.opcode)
      isaPkg::OpAdd:  refRegs[instr.x] = ry + rz;
      isaPkg::OpOr:   refRegs[instr.x] = ry | rz;
      isaPkg::OpAnd:  refRegs[instr.x] = ry & rz;
      isaPkg::OpNot:  refRegs[instr.x] = ~ry;
      isaPkg::OpCopy: refRegs[instr.x] = ry;
      isaPkg::OpCondCopy:
        if (rz != '0)
          refRegs[instr.x] = ry;
      isaPkg::OpLoad:
      begin
        outcome.memAccess  = 1'b1;
        outcome.memAddress = ry;
        refRegs[instr.x]   = refMem[ry[7:0]];
      end
      isaPkg::OpStore:
      begin
        outcome.memAccess  = 1'b1;
        outcome.memWrite   = 1'b1;
        outcome.memAddress = ry;
        outcome.storeData  = refRegs[instr.x];
        refMem[ry[7:0]]    = refRegs[instr.x];
      end
      default: ;  // fetch only
    endcase
    outcome.nextPc = refRegs[15];  // a write to R15 is a jump
    return outcome;
  endfunction

  task automatic compareWord(input string name, input isaPkg::wordT expected,
                             input isaPkg::wordT actual);
    assert (actual === expected)
    else
    begin
      mismatchCount++;
      $display("MISMATCH %s after %0d fetches: expected %h, actual %h",
               name, fetchCount, expected, actual);
    end
  endtask

  task automatic reportAndFinish();
    failureCount += dut.props.violationCount;
    $display("Error counts: %0d mismatches, %0d other failures", mismatchCount, failureCount);
    if ((mismatchCount == 0) && (failureCount == 0))
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // checks every acked bus cycle mid-cycle
  always @(negedge Clock)
  begin
    if (arstN && wbOut.cyc && wbOut.stb && wbIn.ack)
    begin
      if (wbOut.we)
      begin
        storeCount++;  // writes the DUT made
      end
      if (memPending)
      begin
        compareWord("data cycle direction", 16'(pendingStep.memWrite), 16'(wbOut.we));
        compareWord("data cycle address", pendingStep.memAddress, wbOut.adr);
        if (pendingStep.memWrite)
        begin
          compareWord("store data", pendingStep.storeData, wbOut.dat);
        end
        memPending = 1'b0;
      end
      else
      begin
        compareWord("fetch direction", 16'd0, 16'(wbOut.we));
        compareWord("fetch address", expectedPc, wbOut.adr);
        pendingStep = modelInstruction();
        expectedPc  = pendingStep.nextPc;
        memPending  = pendingStep.memAccess;
        fetchCount++;
        if (fetchCount == FetchTarget)
        begin
          compareWord("store count", 16'(ExpectedStores), 16'(storeCount));
          for (int a = 0; a < 256; a++)
          begin
            compareWord($sformatf("memory word %02h", a), refMem[a], memory[a]);
          end
          reportAndFinish();
        end
      end
    end
  end

  always @(posedge Clock)
  begin
    cycleCount++;
    if (cycleCount == CycleLimit)
    begin
      $display("Timeout: the program did not finish within %0d cycles", CycleLimit);
      failureCount++;
      reportAndFinish();
    end
  end

endmodule

/* compile.f */
hdl/isaPkg.sv
hdl/wbPkg.sv
hdl/registerBank.sv
hdl/busInterface.sv
hdl/stepControl.sv
hdl/processorTop.sv
test/stepControl_props.sv
test/processorTb.sv
